// ==== mcpu.f ====
mcpu_pkg.sv
mcpu_ctrl_if.sv
mcpu_alu.sv
mcpu_regfile.sv
mcpu_decoder.sv
mcpu_datapath.sv
mcpu_top.sv
tb_mcpu_iss_pkg.sv
tb_mcpu.sv

// ==== mcpu_alu.sv ====
module mcpu_alu (
    input  mcpu_pkg::alu_op_e         alu_op,
    input  logic [mcpu_pkg::XLEN-1:0] src1,
    input  logic [mcpu_pkg::XLEN-1:0] src2,
    output logic [mcpu_pkg::XLEN-1:0] result
);
    import mcpu_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb begin
        case (alu_op)
            ADD:     result = sum;
            SUB:     result = diff;
            SLT:     result = {31'b0, $signed(src1) < $signed(src2)};
            SLTU:    result = {31'b0, src1 < src2};
            AND:     result = src1 & src2;
            NOR:     result = ~(src1 | src2);
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = $unsigned($signed(src1) >>> shamt);
            LUI:     result = src2;  // Decoder has placed the upper 20 bits
            default: result = sum;
        endcase
    end

endmodule

// ==== mcpu_ctrl_if.sv ====
interface mcpu_ctrl_if;
    import mcpu_pkg::*;

    alu_op_e         alu_op;
    br_kind_e        br_kind;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic            is_load;
    logic            is_store;
    logic            gr_we;
    logic [4:0]      dest;
    logic [4:0]      raddr1;
    logic [4:0]      raddr2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] br_offs;  // Byte offset, already scaled by four

    modport decoder (
        output alu_op, br_kind, src1_is_pc, src2_is_imm, is_load, is_store,
               gr_we, dest, raddr1, raddr2, imm, br_offs
    );

    modport datapath (
        input alu_op, br_kind, src1_is_pc, src2_is_imm, is_load, is_store,
              gr_we, dest, raddr1, raddr2, imm, br_offs
    );

endinterface

// ==== mcpu_datapath.sv ====
module mcpu_datapath #(
    parameter logic [mcpu_pkg::XLEN-1:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                      clk,
    input  logic                      reset,
    output logic [mcpu_pkg::XLEN-1:0] inst_addr,
    input  logic [mcpu_pkg::XLEN-1:0] inst_rdata,
    output logic [mcpu_pkg::XLEN-1:0] inst,
    mcpu_ctrl_if.datapath             ctrl,
    input  logic [mcpu_pkg::XLEN-1:0] rdata1,
    input  logic [mcpu_pkg::XLEN-1:0] rdata2,
    output logic [mcpu_pkg::XLEN-1:0] alu_src1,
    output logic [mcpu_pkg::XLEN-1:0] alu_src2,
    input  logic [mcpu_pkg::XLEN-1:0] alu_result,
    output logic                      data_we,
    output logic [mcpu_pkg::XLEN-1:0] data_addr,
    output logic [mcpu_pkg::XLEN-1:0] data_wdata,
    input  logic [mcpu_pkg::XLEN-1:0] data_rdata,
    output logic                      rf_we,
    output logic [4:0]                rf_waddr,
    output logic [mcpu_pkg::XLEN-1:0] rf_wdata,
    output logic [mcpu_pkg::XLEN-1:0] wb_pc
);
    import mcpu_pkg::*;

    cpu_state_e      state;
    cpu_state_e      state_next;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst_pc;
    logic [XLEN-1:0] inst_r;
    logic [XLEN-1:0] rj_val;
    logic [XLEN-1:0] rkd_val;
    logic [XLEN-1:0] final_res;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] br_target;
    logic            rj_eq_rd;
    logic            br_taken;

    // The fetched word is only on the SRAM port during ID
    assign inst      = (state == ID) ? inst_rdata : inst_r;
    assign inst_addr = pc;

    assign seq_pc    = pc + 32'd4;
    assign rj_eq_rd  = (rdata1 == rdata2);
    assign br_target = (ctrl.br_kind == JIRL) ? rdata1 + ctrl.br_offs : pc + ctrl.br_offs;

    always_comb begin
        case (ctrl.br_kind)
            B, BL, JIRL: br_taken = 1'b1;
            BEQ:         br_taken = rj_eq_rd;
            BNE:         br_taken = !rj_eq_rd;
            default:     br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (state)
            IF: state_next = ID;
            ID: begin
                // Plain branches and unsupported words have nothing left to do
                if ((ctrl.br_kind inside {B, BEQ, BNE}) || !(ctrl.gr_we || ctrl.is_store)) begin
                    state_next = IF;
                end else begin
                    state_next = EXE;
                end
            end
            EXE:     state_next = (ctrl.is_load || ctrl.is_store) ? MEM : WB;
            MEM:     state_next = ctrl.is_load ? WB : IF;
            default: state_next = IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (state == ID) begin
                pc <= br_taken ? br_target : seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ID: begin
                inst_r  <= inst_rdata;
                inst_pc <= pc;  // pc moves on at this edge
                rj_val  <= rdata1;
                rkd_val <= rdata2;
            end
            EXE: final_res <= alu_result;
            MEM: begin
                if (ctrl.is_load) begin
                    final_res <= data_rdata;
                end
            end
            default: ;
        endcase
    end

    assign alu_src1 = ctrl.src1_is_pc ? inst_pc : rj_val;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_val;

    assign data_we    = (state == EXE) && ctrl.is_store;
    assign data_addr  = alu_result;
    assign data_wdata = rkd_val;

    // A write to r0 is dropped here so the trace never reports it
    assign rf_we    = (state == WB) && ctrl.gr_we && (ctrl.dest != 5'd0);
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = final_res;
    assign wb_pc    = inst_pc;

endmodule

// ==== mcpu_decoder.sv ====
module mcpu_decoder (
    input  logic [mcpu_pkg::XLEN-1:0] inst,
    mcpu_ctrl_if.decoder              ctrl
);
    import mcpu_pkg::*;

    logic [4:0]      rd;
    logic [4:0]      rj;
    logic [4:0]      rk;
    logic [XLEN-1:0] si12_ext;
    logic [XLEN-1:0] ui5_ext;
    logic [XLEN-1:0] si20_shl;
    logic [XLEN-1:0] offs16;
    logic [XLEN-1:0] offs26;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign si12_ext = {{20{inst[21]}}, inst[21:10]};
    assign ui5_ext  = {27'b0, inst[14:10]};
    assign si20_shl = {inst[24:5], 12'b0};
    assign offs16   = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26   = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};  // Split offs26 field

    assign ctrl.raddr1 = rj;

    always_comb begin
        ctrl.alu_op      = ADD;
        ctrl.br_kind     = NONE;
        ctrl.src1_is_pc  = 1'b0;
        ctrl.src2_is_imm = 1'b0;
        ctrl.is_load     = 1'b0;
        ctrl.is_store    = 1'b0;
        ctrl.gr_we       = 1'b0;
        ctrl.dest        = rd;
        ctrl.raddr2      = rk;
        ctrl.imm         = si12_ext;
        ctrl.br_offs     = offs16;

        // Match on the opcode bits above rk
        casez (inst[31:15])
            17'h00020: begin ctrl.alu_op = ADD;  ctrl.gr_we = 1'b1; end
            17'h00022: begin ctrl.alu_op = SUB;  ctrl.gr_we = 1'b1; end
            17'h00024: begin ctrl.alu_op = SLT;  ctrl.gr_we = 1'b1; end
            17'h00025: begin ctrl.alu_op = SLTU; ctrl.gr_we = 1'b1; end
            17'h00028: begin ctrl.alu_op = NOR;  ctrl.gr_we = 1'b1; end
            17'h00029: begin ctrl.alu_op = AND;  ctrl.gr_we = 1'b1; end
            17'h0002a: begin ctrl.alu_op = OR;   ctrl.gr_we = 1'b1; end
            17'h0002b: begin ctrl.alu_op = XOR;  ctrl.gr_we = 1'b1; end
            17'h00081, 17'h00089, 17'h00091: begin
                ctrl.alu_op      = (inst[19]) ? SRA : (inst[18]) ? SRL : SLL;
                ctrl.gr_we       = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = ui5_ext;
            end
            17'b0000001010_???????: begin  // addi.w
                ctrl.gr_we       = 1'b1;
                ctrl.src2_is_imm = 1'b1;
            end
            17'b0001010_??????????: begin  // lu12i.w
                ctrl.alu_op      = LUI;
                ctrl.gr_we       = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = si20_shl;
            end
            17'b0010100010_???????: begin
                ctrl.is_load     = 1'b1;
                ctrl.gr_we       = 1'b1;
                ctrl.src2_is_imm = 1'b1;
            end
            17'b0010100110_???????: begin
                ctrl.is_store    = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.raddr2      = rd;  // Store data comes from rd
            end
            17'b010011_???????????: begin
                // Link value pc+4 is formed in the ALU
                ctrl.br_kind     = JIRL;
                ctrl.gr_we       = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
            end
            17'b010100_???????????: begin
                ctrl.br_kind = B;
                ctrl.br_offs = offs26;
            end
            17'b010101_???????????: begin
                ctrl.br_kind     = BL;
                ctrl.br_offs     = offs26;
                ctrl.gr_we       = 1'b1;
                ctrl.dest        = 5'd1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
            end
            17'b010110_???????????: begin ctrl.br_kind = BEQ; ctrl.raddr2 = rd; end
            17'b010111_???????????: begin ctrl.br_kind = BNE; ctrl.raddr2 = rd; end
            default: ;  // Unsupported word decodes as a no-op
        endcase
    end

endmodule

// ==== mcpu_pkg.sv ====
package mcpu_pkg;

    parameter int XLEN = 32;
    parameter int NREG = 32;

    // One state per instruction phase
    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EXE = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } cpu_state_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        AND  = 4'd4,
        NOR  = 4'd5,
        OR   = 4'd6,
        XOR  = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11  // Immediate arrives already shifted
    } alu_op_e;

    // Control transfer resolved in ID
    typedef enum logic [2:0] {
        NONE = 3'd0,
        B    = 3'd1,
        BL   = 3'd2,
        BEQ  = 3'd3,
        BNE  = 3'd4,
        JIRL = 3'd5
    } br_kind_e;

endpackage

// ==== mcpu_regfile.sv ====
module mcpu_regfile (
    input  logic                                clk,
    input  logic [$clog2(mcpu_pkg::NREG)-1:0]   raddr1,
    input  logic [$clog2(mcpu_pkg::NREG)-1:0]   raddr2,
    output logic [mcpu_pkg::XLEN-1:0]           rdata1,
    output logic [mcpu_pkg::XLEN-1:0]           rdata2,
    input  logic                                we,
    input  logic [$clog2(mcpu_pkg::NREG)-1:0]   waddr,
    input  logic [mcpu_pkg::XLEN-1:0]           wdata
);
    import mcpu_pkg::*;

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on both read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== mcpu_top.sv ====
module mcpu_top #(
    parameter logic [mcpu_pkg::XLEN-1:0] RESET_PC = 32'h1c00_0000
) (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      inst_sram_we,
    output logic [mcpu_pkg::XLEN-1:0] inst_sram_addr,
    output logic [mcpu_pkg::XLEN-1:0] inst_sram_wdata,
    input  logic [mcpu_pkg::XLEN-1:0] inst_sram_rdata,
    output logic                      data_sram_we,
    output logic [mcpu_pkg::XLEN-1:0] data_sram_addr,
    output logic [mcpu_pkg::XLEN-1:0] data_sram_wdata,
    input  logic [mcpu_pkg::XLEN-1:0] data_sram_rdata,
    output logic [mcpu_pkg::XLEN-1:0] debug_wb_pc,
    output logic [3:0]                debug_wb_rf_we,
    output logic [4:0]                debug_wb_rf_wnum,
    output logic [mcpu_pkg::XLEN-1:0] debug_wb_rf_wdata
);
    import mcpu_pkg::*;

    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic            rf_we;

    mcpu_ctrl_if ctrl ();

    // Instruction memory is read-only from the core
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    mcpu_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .inst       (inst),
        .ctrl       (ctrl.datapath),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata),
        .rf_we      (rf_we),
        .rf_waddr   (debug_wb_rf_wnum),
        .rf_wdata   (debug_wb_rf_wdata),
        .wb_pc      (debug_wb_pc)
    );

    mcpu_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl.decoder)
    );

    mcpu_alu u_alu (
        .alu_op (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    mcpu_regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (debug_wb_rf_wnum),
        .wdata  (debug_wb_rf_wdata)
    );

    assign debug_wb_rf_we = {4{rf_we}};

endmodule

// ==== tb_mcpu.sv ====
module tb_mcpu;
    timeunit 1ns;
    timeprecision 1ps;
    import tb_mcpu_iss_pkg::*;

    localparam logic [31:0] RESET_PC    = 32'h1c00_0000;
    localparam int          PROG_LEN    = 200;
    localparam logic [31:0] END_PC      = RESET_PC + 4 * (PROG_LEN - 1);
    localparam int          WATCHDOG_NS = PROG_LEN * 5 * 10 * 2 + 3 * 10;
    localparam logic [16:0] OP3R [11]   = '{17'h00020, 17'h00022, 17'h00024, 17'h00025,
                                            17'h00028, 17'h00029, 17'h0002a, 17'h0002b,
                                            17'h00081, 17'h00089, 17'h00091};

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;
    int          pass_count;
    int          fail_count;
    int          events_seen;
    string       test_name;

    mcpu_top #(.RESET_PC(RESET_PC)) u_mcpu_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // SRAMs take the address on the rising edge and answer at the next falling edge
    always @(posedge clk) begin
        inst_addr_q <= inst_sram_addr - RESET_PC;
        data_addr_q <= data_sram_addr;
        if (data_sram_we === 1'b1) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= (inst_addr_q < 32'd1024) ? imem[inst_addr_q[9:2]] : 32'h0;
        data_sram_rdata <= dmem[data_addr_q[9:2]];
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        fail_count++;
    endtask

    task automatic finish_test(input int fails_before);
        $display("test %s: %s", test_name, (fail_count == fails_before) ? "ok" : "errors found");
    endtask

    // r31 keeps RESET_PC so every jirl can reach a forward target
    task automatic build_program();
        int kind;
        int rd;
        int rj;
        int rk;
        int hop;

        imem[0] = {7'h0a, RESET_PC[31:12], 5'd31};
        for (int i = 1; i <= 30; i++) begin
            imem[i] = {10'h00a, 12'($urandom), 5'd0, 5'(i)};  // addi.w ri, r0, si12
        end
        for (int i = 31; i < PROG_LEN - 1; i++) begin
            kind = $urandom_range(19);
            rd   = $urandom_range(30);
            rj   = $urandom_range(31);
            rk   = $urandom_range(31);
            hop  = $urandom_range((PROG_LEN - 1 - i < 6) ? PROG_LEN - 1 - i : 6, 1);
            if (kind >= 18 && $urandom_range(1) == 1) begin
                rk = rj;  // Equal operands so beq and bne go both ways
            end
            case (kind)
                11: imem[i] = {10'h00a, 12'($urandom), 5'(rj), 5'(rd)};
                12: imem[i] = {7'h0a, 20'($urandom), 5'(rd)};
                13: imem[i] = {10'h0a2, 2'b00, 8'($urandom), 2'b00, 5'd0, 5'(rd)};
                14: imem[i] = {10'h0a6, 2'b00, 8'($urandom), 2'b00, 5'd0, 5'(rd)};
                15: imem[i] = {6'h13, 16'(i + hop), 5'd31, 5'(rd)};
                16: imem[i] = {6'h14, 16'(hop), 10'd0};
                17: imem[i] = {6'h15, 16'(hop), 10'd0};
                18, 19: imem[i] = {(kind == 18) ? 6'h16 : 6'h17, 16'(hop), 5'(rj), 5'(rk)};
                default: imem[i] = {OP3R[kind], 5'(rk), 5'(rj), 5'(rd)};
            endcase
        end
        imem[PROG_LEN - 1] = 32'h5000_0000;  // b 0
    endtask

    // Runs the model past branches and writes to r0 up to the next visible event
    task automatic next_event(output step_result_t ev, output logic at_end);
        ev     = '0;
        at_end = 1'b1;
        while (model_pc != END_PC && at_end) begin
            ev     = execute(imem[(model_pc - RESET_PC) >> 2]);
            at_end = !(ev.has_wb || ev.has_store);
        end
    endtask

    task automatic compare_event();
        step_result_t exp;
        logic         at_end;

        next_event(exp, at_end);
        events_seen++;
        if (at_end) begin
            report_error("the core wrote after the program had reached its final loop");
        end else if (data_sram_we === 1'b1 && !exp.has_store) begin
            report_error("a store appeared where the model expects a register write");
        end else if (data_sram_we !== 1'b1 && !exp.has_wb) begin
            report_error("a register write appeared where the model expects a store");
        end else if (exp.has_store) begin
            check("store addr", exp.saddr, data_sram_addr);
            check("store data", exp.sdata, data_sram_wdata);
        end else begin
            check("wb_rf_we", 32'hf, 32'(debug_wb_rf_we));
            check("wb_pc", exp.pc, debug_wb_pc);
            check("wb_rf_wnum", 32'(exp.wnum), 32'(debug_wb_rf_wnum));
            check("wb_rf_wdata", exp.wdata, debug_wb_rf_wdata);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: the core stopped committing before it reached the final loop");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int           fails_before;
        int           end_cycles;
        step_result_t tail;
        logic         at_end;

        void'($urandom(32'h04823de8));
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        pass_count      = 0;
        fail_count      = 0;
        events_seen     = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
        build_program();
        reset_model(RESET_PC);

        test_name    = "reset";
        fails_before = fail_count;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check("rf_we", 32'h0, 32'(debug_wb_rf_we));
            check("data_we", 32'h0, 32'(data_sram_we));
            check("inst_addr", RESET_PC, inst_sram_addr);
            if (c == 2) begin
                reset = 1'b0;
            end
        end
        finish_test(fails_before);

        // Done once the core has sat on the final loop for 20 cycles
        test_name    = "program";
        fails_before = fail_count;
        end_cycles   = 0;
        while (end_cycles < 20) begin
            @(negedge clk);
            check("inst_we", 32'h0, 32'(inst_sram_we));  // Instruction SRAM is never written
            check("inst_wdata", 32'h0, inst_sram_wdata);
            if (data_sram_we !== 1'b0 || debug_wb_rf_we !== 4'h0) begin
                compare_event();
            end
            end_cycles = (inst_sram_addr == END_PC) ? end_cycles + 1 : 0;
        end
        finish_test(fails_before);

        test_name    = "completion";
        fails_before = fail_count;
        next_event(tail, at_end);
        if (!at_end) begin
            report_error("the model expects a write that the core never made");
        end
        if (events_seen == 0) begin
            report_error("no register write or store was seen");
        end
        finish_test(fails_before);

        $display("checks passed %0d, failed %0d, events %0d",
                 pass_count, fail_count, events_seen);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_mcpu_iss_pkg.sv ====
package tb_mcpu_iss_pkg;

    // What one instruction makes visible outside the core
    typedef struct packed {
        logic        has_wb;
        logic        has_store;
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic [31:0] saddr;
        logic [31:0] sdata;
    } step_result_t;

    logic [31:0] model_pc;
    logic [31:0] model_gpr [32];
    logic [31:0] model_dmem [256];

    // Initial data memory contents, every word index gives a different value
    function automatic logic [31:0] fill_word(input logic [31:0] word_idx);
        return (word_idx * 32'h9e37_79b1) ^ 32'h1357_2468;
    endfunction

    function automatic void reset_model(input logic [31:0] start_pc);
        model_pc = start_pc;
        for (int i = 0; i < 32; i++) begin
            model_gpr[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            model_dmem[i] = fill_word(i);
        end
    endfunction

    function automatic step_result_t execute(input logic [31:0] inst);
        step_result_t res;
        logic [4:0]   rd;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  d;
        logic [31:0]  addr;
        logic [31:0]  offs16;
        logic [31:0]  offs26;
        logic [31:0]  val;
        logic [31:0]  next_pc;
        logic         wr;

        rd      = inst[4:0];
        a       = model_gpr[inst[9:5]];
        b       = model_gpr[inst[14:10]];
        d       = model_gpr[rd];
        addr    = a + {{20{inst[21]}}, inst[21:10]};
        offs16  = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        next_pc = model_pc + 32'd4;
        val     = next_pc;  // Link value of bl and jirl
        wr      = 1'b1;
        res     = '0;
        res.pc  = model_pc;

        case (inst[31:15])
            17'h00020: val = a + b;
            17'h00022: val = a - b;
            17'h00024: val = {31'b0, $signed(a) < $signed(b)};
            17'h00025: val = {31'b0, a < b};
            17'h00028: val = ~(a | b);
            17'h00029: val = a & b;
            17'h0002a: val = a | b;
            17'h0002b: val = a ^ b;
            17'h00081: val = a << inst[14:10];
            17'h00089: val = a >> inst[14:10];
            17'h00091: val = $unsigned($signed(a) >>> inst[14:10]);
            default: begin
                case (inst[31:26])
                    6'h00: begin
                        val = addr;
                        wr  = (inst[25:22] == 4'ha);
                    end
                    6'h05: begin
                        val = {inst[24:5], 12'b0};
                        wr  = !inst[25];
                    end
                    6'h0a: begin
                        val = model_dmem[addr[9:2]];
                        wr  = (inst[25:22] == 4'h2);
                        if (inst[25:22] == 4'h6) begin
                            model_dmem[addr[9:2]] = d;
                            res.has_store = 1'b1;
                            res.saddr     = addr;
                            res.sdata     = d;
                        end
                    end
                    6'h13: next_pc = a + offs16;
                    6'h14: begin
                        wr      = 1'b0;
                        next_pc = model_pc + offs26;
                    end
                    6'h15: begin
                        rd      = 5'd1;
                        next_pc = model_pc + offs26;
                    end
                    6'h16, 6'h17: begin
                        wr = 1'b0;
                        // Bit 26 is clear for beq and set for bne
                        if ((a == d) != inst[26]) begin
                            next_pc = model_pc + offs16;
                        end
                    end
                    default: wr = 1'b0;
                endcase
            end
        endcase

        if (wr && rd != 5'd0) begin
            model_gpr[rd] = val;
            res.has_wb    = 1'b1;
            res.wnum      = rd;
            res.wdata     = val;
        end
        model_pc = next_pc;
        return res;
    endfunction

endpackage
